//--- list.f
+incdir+verilog
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_ex_stage.sv
verilog/id_wb_stage.sv
verilog/id_ex_ctrl.sv
tb/id_ex_checker.sv
tb/tb_id_ex_ctrl.sv

//--- Bender.yml
package:
  name: id_ex_ctrl

export_include_dirs:
  - verilog

sources:
  - verilog/id_pkg.sv
  - verilog/id_decoder.sv
  - verilog/id_ex_stage.sv
  - verilog/id_wb_stage.sv
  - verilog/id_ex_ctrl.sv
  - target: test
    files:
      - tb/id_ex_checker.sv
      - tb/tb_id_ex_ctrl.sv

//--- tb/tb_id_ex_ctrl.sv
`include "id_settings.svh"

module tb_id_ex_ctrl;

  timeunit 1ns;
  timeprecision 1ps;

  import id_pkg::*;

  localparam int NumTests = 19;
  localparam int Timeout  = 200;
  localparam logic [31:0] BasePc = 32'h0000_0100;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      instr_req_i;
  instr_word_u               instr_i;
  logic [`ID_XLEN-1:0]       instr_pc_i;
  logic                      instr_ack_o;
  priv_lvl_e                 priv_mode_i;
  logic                      mstatus_tw_i;
  logic                      branch_decision_i;
  logic                      lsu_resp_valid_i;
  logic                      retire_ack_i;
  logic                      illegal_insn_o;
  logic                      pc_set_o;
  logic [`ID_XLEN-1:0]       pc_target_o;
  logic                      wb_req_o;
  wb_type_e                  wb_type_o;
  logic [`ID_REG_ADDR_W-1:0] wb_rd_o;
  logic [`ID_XLEN-1:0]       wb_pc_o;

  // one row of stimulus and expected values per test
  logic [NumTests-1:0][63:0] name_tab;
  logic [NumTests-1:0][31:0] word_tab;
  logic [NumTests-1:0][31:0] pc_tab;
  priv_lvl_e                 priv_tab [NumTests];
  logic [NumTests-1:0]       tw_tab;
  logic [NumTests-1:0]       bd_tab;
  logic [NumTests-1:0][1:0]  type_tab;
  logic [NumTests-1:0][4:0]  rd_tab;
  logic [NumTests-1:0]       set_tab;
  logic [NumTests-1:0][31:0] target_tab;
  logic [NumTests-1:0]       muldiv_tab;

  int row_idx;
  int captured_cnt;
  int retired_cnt;
  int err_cnt;
  int done_cnt;
  int seed = 32'h5fbb_7a57;

  //////////////////////////////////////////////////////////////////////
  // clock, dut and checker
  //////////////////////////////////////////////////////////////////////

  always #2 clk_i = ~clk_i;

  id_ex_ctrl i_id_ex_ctrl (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .instr_req_i       (instr_req_i),
    .instr_i           (instr_i),
    .instr_pc_i        (instr_pc_i),
    .instr_ack_o       (instr_ack_o),
    .priv_mode_i       (priv_mode_i),
    .mstatus_tw_i      (mstatus_tw_i),
    .branch_decision_i (branch_decision_i),
    .lsu_resp_valid_i  (lsu_resp_valid_i),
    .retire_ack_i      (retire_ack_i),
    .illegal_insn_o    (illegal_insn_o),
    .pc_set_o          (pc_set_o),
    .pc_target_o       (pc_target_o),
    .wb_req_o          (wb_req_o),
    .wb_type_o         (wb_type_o),
    .wb_rd_o           (wb_rd_o),
    .wb_pc_o           (wb_pc_o)
  );

  id_ex_checker #(
    .NumTests (NumTests)
  ) i_id_ex_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_ack_i      (instr_ack_o),
    .illegal_insn_i   (illegal_insn_o),
    .pc_set_i         (pc_set_o),
    .pc_target_i      (pc_target_o),
    .wb_req_i         (wb_req_o),
    .wb_type_i        (wb_type_o),
    .wb_rd_i          (wb_rd_o),
    .wb_pc_i          (wb_pc_o),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .name_i           (name_tab),
    .exp_type_i       (type_tab),
    .exp_rd_i         (rd_tab),
    .exp_pc_i         (pc_tab),
    .exp_set_i        (set_tab),
    .exp_target_i     (target_tab),
    .muldiv_i         (muldiv_tab),
    .err_cnt_o        (err_cnt),
    .done_cnt_o       (done_cnt)
  );

  //////////////////////////////////////////////////////////////////////
  // table
  //////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic [63:0] name, input logic [31:0] word, input priv_lvl_e priv,
                         input logic tw, input logic bd, input wb_type_e typ,
                         input logic [4:0] rd, input logic set, input logic [31:0] target,
                         input logic muldiv);
    name_tab[row_idx]   = name;
    word_tab[row_idx]   = word;
    pc_tab[row_idx]     = BasePc + 32'(4 * row_idx);
    priv_tab[row_idx]   = priv;
    tw_tab[row_idx]     = tw;
    bd_tab[row_idx]     = bd;
    type_tab[row_idx]   = typ;
    rd_tab[row_idx]     = rd;
    set_tab[row_idx]    = set;
    target_tab[row_idx] = target;
    muldiv_tab[row_idx] = muldiv;
    row_idx++;
  endtask

  // pc of row n is 0x100 + 4n
  // targets worked out by hand from the immediates
  // store and bad opcode words carry nonzero bits in the rd field
  task automatic fill_table();
    row_idx = 0;
    add_row("alu_addi", 32'h0010_0293, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd5, 1'b0, '0, 1'b0);
    add_row("store_sw", 32'h0050_2223, PRIV_M, 1'b0, 1'b0, WB_STORE,   5'd0, 1'b0, '0, 1'b0);
    add_row("bad_opc ", 32'h0000_02ff, PRIV_M, 1'b0, 1'b0, WB_ILLEGAL, 5'd0, 1'b0, '0, 1'b0);
    add_row("mret_u  ", 32'h3020_0073, PRIV_U, 1'b0, 1'b0, WB_ILLEGAL, 5'd0, 1'b0, '0, 1'b0);
    add_row("mret_m  ", 32'h3020_0073, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd0, 1'b0, '0, 1'b0);
    add_row("wfi_u_tw", 32'h1050_0073, PRIV_U, 1'b1, 1'b0, WB_ILLEGAL, 5'd0, 1'b0, '0, 1'b0);
    add_row("wfi_u   ", 32'h1050_0073, PRIV_U, 1'b0, 1'b0, WB_OTHER,   5'd0, 1'b0, '0, 1'b0);
    // beq +16 taken then not taken
    add_row("beq_tkn ", 32'h0000_0863, PRIV_M, 1'b0, 1'b1, WB_OTHER,   5'd0, 1'b1,
            32'h0000_012c, 1'b0);
    add_row("beq_ntkn", 32'h0000_0863, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd0, 1'b0, '0, 1'b0);
    // bne -8 taken
    add_row("bne_back", 32'hfe00_1ce3, PRIV_M, 1'b0, 1'b1, WB_OTHER,   5'd0, 1'b1,
            32'h0000_011c, 1'b0);
    // jal x1 +256 and jal x0 -4
    add_row("jal_fwd ", 32'h1000_00ef, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd1, 1'b1,
            32'h0000_0228, 1'b0);
    add_row("jal_back", 32'hffdf_f06f, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd0, 1'b1,
            32'h0000_0128, 1'b0);
    add_row("mul     ", 32'h0220_81b3, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd3, 1'b0, '0, 1'b1);
    add_row("add     ", 32'h0020_8233, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd4, 1'b0, '0, 1'b0);
    add_row("lw_x6   ", 32'h0000_2303, PRIV_M, 1'b0, 1'b0, WB_LOAD,    5'd6, 1'b0, '0, 1'b0);
    add_row("addi_x7 ", 32'h0070_0393, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd7, 1'b0, '0, 1'b0);
    add_row("lw_x8   ", 32'h0000_2403, PRIV_M, 1'b0, 1'b0, WB_LOAD,    5'd8, 1'b0, '0, 1'b0);
    add_row("div     ", 32'h0220_c4b3, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd9, 1'b0, '0, 1'b1);
    add_row("addi_x10", 32'h0010_0513, PRIV_M, 1'b0, 1'b0, WB_OTHER,   5'd10, 1'b0, '0, 1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // bounded waits
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("ERROR: timed out waiting for %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (rst_ni !== 1'b1 && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (rst_ni !== 1'b1) abort_run("reset release");
  endtask

  task automatic wait_fetch_ack(input logic level);
    int cnt;
    cnt = 0;
    while (instr_ack_o !== level && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (instr_ack_o !== level) abort_run("instr_ack_o");
  endtask

  task automatic wait_wb_req(input logic level);
    int cnt;
    cnt = 0;
    while (wb_req_o !== level && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (wb_req_o !== level) abort_run("wb_req_o");
  endtask

  task automatic wait_retired(input int n);
    int cnt;
    cnt = 0;
    while (retired_cnt < n && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (retired_cnt < n) abort_run("retirement");
  endtask

  task automatic wait_captured(input int n);
    int cnt;
    cnt = 0;
    while (captured_cnt < n && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    if (captured_cnt < n) abort_run("fetch capture");
  endtask

  task automatic random_delay();
    int n;
    n = $unsigned($random(seed)) % 6;
    repeat (n) @(negedge clk_i);
  endtask

  //////////////////////////////////////////////////////////////////////
  // fetch driver
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk_i             = 1'b0;
    rst_ni            = 1'b0;
    instr_req_i       = 1'b0;
    instr_i           = '0;
    instr_pc_i        = '0;
    priv_mode_i       = PRIV_M;
    mstatus_tw_i      = 1'b0;
    branch_decision_i = 1'b0;
    lsu_resp_valid_i  = 1'b0;
    retire_ack_i      = 1'b0;
    captured_cnt      = 0;
    retired_cnt       = 0;
    fill_table();
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    for (int i = 0; i < NumTests; i++) begin
      // side inputs are read while the previous word is still decoded
      if (i > 0 && (priv_tab[i] != priv_tab[i-1] || tw_tab[i] != tw_tab[i-1] ||
                    bd_tab[i] != bd_tab[i-1])) begin
        wait_retired(i);
      end
      instr_i           = word_tab[i];
      instr_pc_i        = pc_tab[i];
      priv_mode_i       = priv_tab[i];
      mstatus_tw_i      = tw_tab[i];
      branch_decision_i = bd_tab[i];
      instr_req_i       = 1'b1;
      wait_fetch_ack(1'b1);
      captured_cnt = i + 1;
      instr_req_i  = 1'b0;
      wait_fetch_ack(1'b0);
    end

    wait_retired(NumTests);
    repeat (4) @(negedge clk_i);
    $display("summary: %0d of %0d tests retired, %0d errors", done_cnt, NumTests, err_cnt);
    if (err_cnt == 0 && done_cnt == NumTests) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // retire and memory responders
  //////////////////////////////////////////////////////////////////////

  // four-phase consumer with random ack delays
  initial begin
    wait_reset_release();
    for (int k = 0; k < NumTests; k++) begin
      wait_wb_req(1'b1);
      random_delay();
      retire_ack_i = 1'b1;
      wait_wb_req(1'b0);
      random_delay();
      retire_ack_i = 1'b0;
      retired_cnt++;
    end
  end

  // a load is in writeback once it is captured and all older ones retired
  initial begin
    wait_reset_release();
    for (int i = 0; i < NumTests; i++) begin
      if (type_tab[i] == WB_LOAD) begin
        wait_captured(i + 1);
        wait_retired(i);
        repeat (3) @(negedge clk_i);
        random_delay();
        lsu_resp_valid_i = 1'b1;
        @(negedge clk_i);
        lsu_resp_valid_i = 1'b0;
      end
    end
  end

endmodule

//--- tb/id_ex_checker.sv
`include "id_settings.svh"

module id_ex_checker #(
  parameter int NumTests = 19
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // observed dut ports
  input  logic                      instr_ack_i,
  input  logic                      illegal_insn_i,
  input  logic                      pc_set_i,
  input  logic [31:0]               pc_target_i,
  input  logic                      wb_req_i,
  input  logic [1:0]                wb_type_i,
  input  logic [4:0]                wb_rd_i,
  input  logic [31:0]               wb_pc_i,
  input  logic                      lsu_resp_valid_i,
  // expected values per test
  input  logic [NumTests-1:0][63:0] name_i,
  input  logic [NumTests-1:0][1:0]  exp_type_i,
  input  logic [NumTests-1:0][4:0]  exp_rd_i,
  input  logic [NumTests-1:0][31:0] exp_pc_i,
  input  logic [NumTests-1:0]       exp_set_i,
  input  logic [NumTests-1:0][31:0] exp_target_i,
  input  logic [NumTests-1:0]       muldiv_i,
  output int                        err_cnt_o,
  output int                        done_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import id_pkg::*;

  int   acks;
  int   cycle;
  int   last_ack_cycle;
  int   row_errs;
  int   set_cnt [NumTests];
  logic ill_seen [NumTests];
  logic resp_seen;
  logic ack_q;
  logic req_q;

  task automatic compare(input logic [63:0] name, input string what, input int exp,
                         input int act);
    if (exp != act) begin
      $display("Mismatch %s %s: expected %0h, actual %0h", name, what, exp, act);
      row_errs++;
      err_cnt_o++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // sampling on the rising edge, inputs settle on the falling one
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acks           = 0;
      cycle          = 0;
      last_ack_cycle = 0;
      err_cnt_o      = 0;
      done_cnt_o     = 0;
      resp_seen      = 1'b0;
      ack_q          = 1'b0;
      req_q          = 1'b0;
      for (int i = 0; i < NumTests; i++) begin
        set_cnt[i]  = 0;
        ill_seen[i] = 1'b0;
      end
    end else begin
      cycle++;
      // new capture, the word now sits in id/ex
      if (instr_ack_i && !ack_q) begin
        if (acks > 0 && acks <= NumTests && muldiv_i[acks-1]) begin
          row_errs = 0;
          compare(name_i[acks-1], "muldiv min gap", `ID_MULDIV_CYCLES,
                  (cycle - last_ack_cycle < `ID_MULDIV_CYCLES) ? cycle - last_ack_cycle
                                                                : `ID_MULDIV_CYCLES);
        end
        last_ack_cycle = cycle;
        acks++;
      end
      if (illegal_insn_i && acks > 0 && acks <= NumTests) begin
        ill_seen[acks-1] = 1'b1;
      end
      // pc set belongs to the word in id/ex
      if (pc_set_i) begin
        if (acks == 0 || acks > NumTests) begin
          $display("ERROR: pc_set_o pulsed with no instruction in flight");
          err_cnt_o++;
        end else begin
          set_cnt[acks-1]++;
          row_errs = 0;
          compare(name_i[acks-1], "pc_target", exp_target_i[acks-1], pc_target_i);
        end
      end
      if (lsu_resp_valid_i) begin
        resp_seen = 1'b1;
      end
      // retirement in table order
      if (wb_req_i && !req_q) begin
        if (done_cnt_o >= NumTests) begin
          $display("ERROR: more instructions retired than were fetched");
          err_cnt_o++;
        end else begin
          row_errs = 0;
          compare(name_i[done_cnt_o], "wb_type", exp_type_i[done_cnt_o], wb_type_i);
          compare(name_i[done_cnt_o], "wb_rd", exp_rd_i[done_cnt_o], wb_rd_i);
          compare(name_i[done_cnt_o], "wb_pc", exp_pc_i[done_cnt_o], wb_pc_i);
          compare(name_i[done_cnt_o], "pc_set count", exp_set_i[done_cnt_o],
                  set_cnt[done_cnt_o]);
          compare(name_i[done_cnt_o], "illegal_insn", exp_type_i[done_cnt_o] == WB_ILLEGAL,
                  ill_seen[done_cnt_o]);
          // a load may only retire after its memory response
          if (exp_type_i[done_cnt_o] == WB_LOAD && !resp_seen) begin
            $display("ERROR: %s retired before its memory response", name_i[done_cnt_o]);
            row_errs++;
            err_cnt_o++;
          end
          if (row_errs == 0) begin
            $display("test %0d %s ok", done_cnt_o, name_i[done_cnt_o]);
          end else begin
            $display("test %0d %s failed, %0d errors", done_cnt_o, name_i[done_cnt_o],
                     row_errs);
          end
          done_cnt_o++;
        end
        resp_seen = 1'b0;
      end
      ack_q = instr_ack_i;
      req_q = wb_req_i;
    end
  end

endmodule

//--- verilog/id_ex_ctrl.sv
`include "id_settings.svh"

module id_ex_ctrl #(
  parameter bit BranchTargetAlu = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // fetch port
  input  logic                      instr_req_i,
  input  id_pkg::instr_word_u       instr_i,
  input  logic [`ID_XLEN-1:0]       instr_pc_i,
  output logic                      instr_ack_o,
  // privilege and execute status
  input  id_pkg::priv_lvl_e         priv_mode_i,
  input  logic                      mstatus_tw_i,
  input  logic                      branch_decision_i,
  input  logic                      lsu_resp_valid_i,
  // retire port
  input  logic                      retire_ack_i,
  output logic                      illegal_insn_o,
  output logic                      pc_set_o,
  output logic [`ID_XLEN-1:0]       pc_target_o,
  output logic                      wb_req_o,
  output id_pkg::wb_type_e          wb_type_o,
  output logic [`ID_REG_ADDR_W-1:0] wb_rd_o,
  output logic [`ID_XLEN-1:0]       wb_pc_o
);

  import id_pkg::*;

  // decoder to id/ex
  logic                      id_valid;
  instr_word_u               id_word;
  logic [`ID_XLEN-1:0]       id_pc;
  instr_kind_e               id_kind;
  logic                      ex_done;
  // id/ex to writeback
  logic                      wb_free;
  logic                      wb_push;
  wb_type_e                  wb_push_type;
  logic [`ID_REG_ADDR_W-1:0] wb_push_rd;
  logic [`ID_XLEN-1:0]       wb_push_pc;

  id_decoder i_id_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .instr_req_i    (instr_req_i),
    .instr_i        (instr_i),
    .instr_pc_i     (instr_pc_i),
    .instr_ack_o    (instr_ack_o),
    .priv_mode_i    (priv_mode_i),
    .mstatus_tw_i   (mstatus_tw_i),
    .ex_done_i      (ex_done),
    .id_valid_o     (id_valid),
    .id_word_o      (id_word),
    .id_pc_o        (id_pc),
    .id_kind_o      (id_kind),
    .illegal_insn_o (illegal_insn_o)
  );

  id_ex_stage #(
    .BranchTargetAlu (BranchTargetAlu)
  ) i_id_ex_stage (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .id_valid_i        (id_valid),
    .id_word_i         (id_word),
    .id_pc_i           (id_pc),
    .id_kind_i         (id_kind),
    .branch_decision_i (branch_decision_i),
    .wb_free_i         (wb_free),
    .ex_done_o         (ex_done),
    .pc_set_o          (pc_set_o),
    .pc_target_o       (pc_target_o),
    .wb_push_o         (wb_push),
    .wb_push_type_o    (wb_push_type),
    .wb_push_rd_o      (wb_push_rd),
    .wb_push_pc_o      (wb_push_pc)
  );

  id_wb_stage i_id_wb_stage (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .wb_push_i        (wb_push),
    .wb_push_type_i   (wb_push_type),
    .wb_push_rd_i     (wb_push_rd),
    .wb_push_pc_i     (wb_push_pc),
    .lsu_resp_valid_i (lsu_resp_valid_i),
    .retire_ack_i     (retire_ack_i),
    .wb_free_o        (wb_free),
    .wb_req_o         (wb_req_o),
    .wb_type_o        (wb_type_o),
    .wb_rd_o          (wb_rd_o),
    .wb_pc_o          (wb_pc_o)
  );

endmodule

//--- verilog/id_wb_stage.sv
`include "id_settings.svh"

module id_wb_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // push from id/ex
  input  logic                      wb_push_i,
  input  id_pkg::wb_type_e          wb_push_type_i,
  input  logic [`ID_REG_ADDR_W-1:0] wb_push_rd_i,
  input  logic [`ID_XLEN-1:0]       wb_push_pc_i,
  // load data has come back
  input  logic                      lsu_resp_valid_i,
  // retire port, four-phase
  input  logic                      retire_ack_i,
  output logic                      wb_free_o,
  output logic                      wb_req_o,
  output id_pkg::wb_type_e          wb_type_o,
  output logic [`ID_REG_ADDR_W-1:0] wb_rd_o,
  output logic [`ID_XLEN-1:0]       wb_pc_o
);

  import id_pkg::*;

  typedef enum logic [1:0] {
    WB_EMPTY,
    WB_WAIT_RESP,
    WB_REQ,
    WB_DRAIN
  } wb_state_e;

  wb_state_e                 state_q;
  wb_type_e                  type_q;
  logic [`ID_REG_ADDR_W-1:0] rd_q;
  logic [`ID_XLEN-1:0]       pc_q;

  //////////////////////////////////////////////////////////////////////
  // slot state
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= WB_EMPTY;
    end else begin
      case (state_q)
        // loads park here until memory answers
        WB_EMPTY: begin
          if (wb_push_i) begin
            state_q <= (wb_push_type_i == WB_LOAD) ? WB_WAIT_RESP : WB_REQ;
          end
        end
        WB_WAIT_RESP: begin
          if (lsu_resp_valid_i) begin
            state_q <= WB_REQ;
          end
        end
        // req drops as soon as ack is seen
        WB_REQ: begin
          if (retire_ack_i) begin
            state_q <= WB_DRAIN;
          end
        end
        // wait for the consumer to release ack
        WB_DRAIN: begin
          if (!retire_ack_i) begin
            state_q <= WB_EMPTY;
          end
        end
        default: begin
          state_q <= WB_EMPTY;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_push_i && (state_q == WB_EMPTY)) begin
      type_q <= wb_push_type_i;
      rd_q   <= wb_push_rd_i;
      pc_q   <= wb_push_pc_i;
    end
  end

  assign wb_free_o = (state_q == WB_EMPTY);
  assign wb_req_o  = (state_q == WB_REQ);
  assign wb_type_o = type_q;
  assign wb_rd_o   = rd_q;
  assign wb_pc_o   = pc_q;

endmodule

//--- verilog/id_ex_stage.sv
`include "id_settings.svh"

module id_ex_stage #(
  parameter bit BranchTargetAlu = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // from the decoder
  input  logic                      id_valid_i,
  input  id_pkg::instr_word_u       id_word_i,
  input  logic [`ID_XLEN-1:0]       id_pc_i,
  input  id_pkg::instr_kind_e       id_kind_i,
  input  logic                      branch_decision_i,
  input  logic                      wb_free_i,
  output logic                      ex_done_o,
  // pc set towards fetch
  output logic                      pc_set_o,
  output logic [`ID_XLEN-1:0]       pc_target_o,
  // handoff into writeback
  output logic                      wb_push_o,
  output id_pkg::wb_type_e          wb_push_type_o,
  output logic [`ID_REG_ADDR_W-1:0] wb_push_rd_o,
  output logic [`ID_XLEN-1:0]       wb_push_pc_o
);

  import id_pkg::*;

  localparam int unsigned CntW = $clog2(`ID_MULDIV_CYCLES);

  typedef enum logic {
    FIRST_CYCLE,
    MULTI_CYCLE
  } ex_fsm_e;

  ex_fsm_e             fsm_q, fsm_d;
  logic [CntW-1:0]     cnt_q, cnt_d;
  logic                work_done;
  logic                set_raw;
  logic                set_done_q;
  logic [`ID_XLEN-1:0] imm_b;
  logic [`ID_XLEN-1:0] imm_j;

  //////////////////////////////////////////////////////////////////////
  // id/ex fsm
  //////////////////////////////////////////////////////////////////////

  // work_done means the instruction has finished its own cycles,
  // it still waits for a free writeback slot before leaving
  always_comb begin
    fsm_d     = fsm_q;
    cnt_d     = cnt_q;
    work_done = 1'b0;
    set_raw   = 1'b0;

    if (id_valid_i) begin
      case (fsm_q)
        FIRST_CYCLE: begin
          case (id_kind_i)
            KIND_MULDIV: begin
              // first cycle counts as one, the rest run in MULTI_CYCLE
              fsm_d = MULTI_CYCLE;
              cnt_d = CntW'(`ID_MULDIV_CYCLES - 2);
            end
            KIND_BRANCH: begin
              // decision is sampled here, only taken branches stay on
              if (!branch_decision_i) begin
                work_done = 1'b1;
              end else if (BranchTargetAlu) begin
                set_raw   = 1'b1;
                work_done = 1'b1;
              end else begin
                fsm_d = MULTI_CYCLE;
              end
            end
            KIND_JUMP: begin
              if (BranchTargetAlu) begin
                set_raw   = 1'b1;
                work_done = 1'b1;
              end else begin
                fsm_d = MULTI_CYCLE;
              end
            end
            // alu, load, store, system and illegal take a single cycle
            default: begin
              work_done = 1'b1;
            end
          endcase
        end

        MULTI_CYCLE: begin
          if (id_kind_i == KIND_MULDIV) begin
            if (cnt_q == '0) begin
              work_done = 1'b1;
            end else begin
              cnt_d = cnt_q - 1'b1;
            end
          end else begin
            // second cycle of a taken branch or jump, target is ready
            set_raw   = 1'b1;
            work_done = 1'b1;
          end
          if (work_done && wb_free_i) begin
            fsm_d = FIRST_CYCLE;
          end
        end

        default: begin
          fsm_d = FIRST_CYCLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fsm_q      <= FIRST_CYCLE;
      cnt_q      <= '0;
      set_done_q <= 1'b0;
    end else begin
      fsm_q      <= fsm_d;
      cnt_q      <= cnt_d;
      // remember the pc set until the instruction leaves
      set_done_q <= (set_raw | set_done_q) & ~ex_done_o;
    end
  end

  assign ex_done_o = work_done & wb_free_i;

  //////////////////////////////////////////////////////////////////////
  // branch and jump target
  //////////////////////////////////////////////////////////////////////

  assign imm_b = {{(`ID_XLEN - 13){id_word_i.b.imm12}}, id_word_i.b.imm12, id_word_i.b.imm11,
                  id_word_i.b.imm10_5, id_word_i.b.imm4_1, 1'b0};
  assign imm_j = {{(`ID_XLEN - 21){id_word_i.j.imm20}}, id_word_i.j.imm20,
                  id_word_i.j.imm19_12, id_word_i.j.imm11, id_word_i.j.imm10_1, 1'b0};

  assign pc_target_o = id_pc_i + ((id_kind_i == KIND_JUMP) ? imm_j : imm_b);
  // only the first raw request of an instruction goes out
  assign pc_set_o    = set_raw & ~set_done_q;

  //////////////////////////////////////////////////////////////////////
  // writeback handoff
  //////////////////////////////////////////////////////////////////////

  assign wb_push_o    = ex_done_o;
  assign wb_push_pc_o = id_pc_i;

  always_comb begin
    case (id_kind_i)
      KIND_LOAD:    wb_push_type_o = WB_LOAD;
      KIND_STORE:   wb_push_type_o = WB_STORE;
      KIND_ILLEGAL: wb_push_type_o = WB_ILLEGAL;
      default:      wb_push_type_o = WB_OTHER;
    endcase
  end

  // no register write for stores, branches and illegal words
  always_comb begin
    case (id_kind_i)
      KIND_STORE, KIND_BRANCH, KIND_ILLEGAL: wb_push_rd_o = '0;
      default:                               wb_push_rd_o = id_word_i.r.rd;
    endcase
  end

endmodule

//--- verilog/id_decoder.sv
`include "id_settings.svh"

module id_decoder (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  // fetch port, four-phase
  input  logic                     instr_req_i,
  input  id_pkg::instr_word_u      instr_i,
  input  logic [`ID_XLEN-1:0]      instr_pc_i,
  output logic                     instr_ack_o,
  // privilege state for the system checks
  input  id_pkg::priv_lvl_e        priv_mode_i,
  input  logic                     mstatus_tw_i,
  // towards id/ex
  input  logic                     ex_done_i,
  output logic                     id_valid_o,
  output id_pkg::instr_word_u      id_word_o,
  output logic [`ID_XLEN-1:0]      id_pc_o,
  output id_pkg::instr_kind_e      id_kind_o,
  output logic                     illegal_insn_o
);

  import id_pkg::*;

  logic        ack_q;
  logic        valid_q;
  instr_word_u word_q;
  logic [`ID_XLEN-1:0] pc_q;
  logic        capture;
  logic        mret_illegal;
  logic        wfi_illegal;

  //////////////////////////////////////////////////////////////////////
  // fetch handshake and instruction register
  //////////////////////////////////////////////////////////////////////

  // take a word only on a fresh request into an empty register
  assign capture = instr_req_i & ~ack_q & ~valid_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // ack rises with the capture edge, falls once req is seen low
      if (capture) begin
        ack_q <= 1'b1;
      end else if (!instr_req_i) begin
        ack_q <= 1'b0;
      end
      // valid until id/ex reports the instruction done
      if (capture) begin
        valid_q <= 1'b1;
      end else if (ex_done_i) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (capture) begin
      word_q <= instr_i;
      pc_q   <= instr_pc_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////////////////////////

  // mret needs machine mode
  assign mret_illegal = (word_q == `ID_SYS_MRET) && (priv_mode_i != PRIV_M);
  // wfi traps outside machine mode only when tw is set
  assign wfi_illegal  = (word_q == `ID_SYS_WFI) && (priv_mode_i != PRIV_M) && mstatus_tw_i;

  always_comb begin
    case (word_q.r.opcode)
      `ID_OPC_LOAD:   id_kind_o = KIND_LOAD;
      `ID_OPC_STORE:  id_kind_o = KIND_STORE;
      `ID_OPC_BRANCH: id_kind_o = KIND_BRANCH;
      `ID_OPC_JAL:    id_kind_o = KIND_JUMP;
      `ID_OPC_OP_IMM: id_kind_o = KIND_ALU;
      // M extension shares the OP opcode
      `ID_OPC_OP: begin
        id_kind_o = (word_q.r.funct7 == `ID_FUNCT7_MULDIV) ? KIND_MULDIV : KIND_ALU;
      end
      `ID_OPC_SYSTEM: begin
        id_kind_o = (mret_illegal || wfi_illegal) ? KIND_ILLEGAL : KIND_SYSTEM;
      end
      // anything else is not implemented
      default:        id_kind_o = KIND_ILLEGAL;
    endcase
  end

  assign instr_ack_o    = ack_q;
  assign id_valid_o     = valid_q;
  assign id_word_o      = word_q;
  assign id_pc_o        = pc_q;
  assign illegal_insn_o = valid_q & (id_kind_o == KIND_ILLEGAL);

endmodule

//--- verilog/id_pkg.sv
`include "id_settings.svh"

package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // instruction word views
  //////////////////////////////////////////////////////////////////////

  // one 32 bit word seen three ways
  // r view for classification and rd, b and j views for the target
  typedef union packed {
    struct packed {
      logic [6:0]                funct7;
      logic [`ID_REG_ADDR_W-1:0] rs2;
      logic [`ID_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [`ID_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } r;
    // branch immediate is scattered around rd and funct7
    struct packed {
      logic                      imm12;
      logic [5:0]                imm10_5;
      logic [`ID_REG_ADDR_W-1:0] rs2;
      logic [`ID_REG_ADDR_W-1:0] rs1;
      logic [2:0]                funct3;
      logic [3:0]                imm4_1;
      logic                      imm11;
      logic [6:0]                opcode;
    } b;
    // jal immediate fills everything above rd
    struct packed {
      logic                      imm20;
      logic [9:0]                imm10_1;
      logic                      imm11;
      logic [7:0]                imm19_12;
      logic [`ID_REG_ADDR_W-1:0] rd;
      logic [6:0]                opcode;
    } j;
  } instr_word_u;

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  // what the decoder made of the word
  typedef enum logic [2:0] {
    KIND_ALU,
    KIND_MULDIV,
    KIND_BRANCH,
    KIND_JUMP,
    KIND_LOAD,
    KIND_STORE,
    KIND_SYSTEM,
    KIND_ILLEGAL
  } instr_kind_e;

  // class of the retiring instruction, visible on the retire port
  typedef enum logic [1:0] {
    WB_OTHER,
    WB_LOAD,
    WB_STORE,
    WB_ILLEGAL
  } wb_type_e;

  // only user and machine mode exist here
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } priv_lvl_e;

endpackage

//--- verilog/id_settings.svh
`ifndef ID_SETTINGS_SVH
`define ID_SETTINGS_SVH

// instruction word and pc width
`define ID_XLEN          32
// register file address width
`define ID_REG_ADDR_W    5

// cycles a multiply/divide stays in id/ex, must be 2 or more
`define ID_MULDIV_CYCLES 4

// major opcodes recognised by the decoder
`define ID_OPC_LOAD      7'b0000011
`define ID_OPC_STORE     7'b0100011
`define ID_OPC_BRANCH    7'b1100011
`define ID_OPC_JAL       7'b1101111
`define ID_OPC_OP        7'b0110011
`define ID_OPC_OP_IMM    7'b0010011
`define ID_OPC_SYSTEM    7'b1110011

// funct7 of the M extension inside OP
`define ID_FUNCT7_MULDIV 7'b0000001

// full encodings of the privileged system instructions that get checked
`define ID_SYS_MRET      32'h3020_0073
`define ID_SYS_WFI       32'h1050_0073

`endif
